// File: sim.f
source/noc_params_pkg.sv
source/alloc_types_pkg.sv
source/rr_arbiter.sv
source/ovc_candidate_select.sv
source/input_port_alloc.sv
source/output_port_alloc.sv
source/comb_nonspec_allocator.sv
tests/comb_nonspec_allocator_chk.sv
tests/tb_comb_nonspec_allocator.sv

// File: run.sh
#!/bin/sh
# compile and run the allocator testbench with verilator

cd "$(dirname "$0")" || exit 1

top=tb_comb_nonspec_allocator
log=sim.log

verilator --binary --timing --assert --top-module "$top" -f sim.f -o "$top" > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$log"; then
    exit 1
fi
exit 0

// File: tests/tb_comb_nonspec_allocator.sv
`timescale 1ns/1ps

module tb_comb_nonspec_allocator
    import noc_params_pkg::*;
    import alloc_types_pkg::*;
();

    localparam int CYCLE_LIMIT = 1000;

    logic        clk;
    logic        reset;
    ivc_info_t   ivc_info [P][V];
    port_grant_t port_grant [P];
    dest_mask_t  granted_dest_port [P];
    vc_mask_t    ovc_allocated [P];
    port_mask_t  any_ovc_granted;

    ivc_info_t stim [P][V]; // copied onto the DUT inputs at the next drive slot

    // reference model pointers, plain indices
    int cand_ptr [P][V];
    int vc_ptr [P];
    int out_ptr [P];

    int error_count;
    int check_count;

    comb_nonspec_allocator i_comb_nonspec_allocator (
        .clk               (clk),
        .reset             (reset),
        .ivc_info          (ivc_info),
        .port_grant        (port_grant),
        .granted_dest_port (granted_dest_port),
        .ovc_allocated     (ovc_allocated),
        .any_ovc_granted   (any_ovc_granted)
    );

    bind comb_nonspec_allocator comb_nonspec_allocator_chk i_comb_nonspec_allocator_chk (
        .clk               (clk),
        .reset             (reset),
        .port_grant        (port_grant),
        .granted_dest_port (granted_dest_port),
        .any_ovc_granted   (any_ovc_granted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // watchdog
    initial begin
        for (int c = 0; c < CYCLE_LIMIT; c++) begin
            @(posedge clk);
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test FAILED");
        $finish;
    end

    // first requester at or above ptr, rising order with wrap, -1 when none
    function automatic int rr_pick(input logic [7:0] req, input int width, input int ptr);
        int idx;
        for (int k = 0; k < width; k++) begin
            idx = (ptr + k) % width;
            if (req[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    // relative destination bit of output o as seen from input i
    function automatic int rel_bit(input int i, input int o);
        return (o < i) ? o : o - 1;
    endfunction

    task automatic check_value(input string name, input int idx, input logic [15:0] got,
                               input logic [15:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s[%0d] got %h expected %h at %0t", name, idx, got, exp, $time);
        end
    endtask

    // predicts all outputs from the arbitration rules, compares, then advances the pointers
    task automatic check_cycle();
        int             cand_idx [P][V];
        int             vc_win [P];
        int             out_pos [P];
        int             jw;
        logic [V-1:0]   vc_req;
        logic [P_1-1:0] oreq;
        dest_mask_t     bid_dest [P];
        port_grant_t    exp_grant [P];
        dest_mask_t     exp_dest [P];
        vc_mask_t       exp_alloc [P];
        port_mask_t     exp_any;

        exp_any = '0;
        for (int i = 0; i < P; i++) begin
            vc_req = '0;
            for (int j = 0; j < V; j++) begin
                cand_idx[i][j] = rr_pick(8'(ivc_info[i][j].ovc_request), V, cand_ptr[i][j]);
                vc_req[j] = ((|ivc_info[i][j].ovc_request) && !ivc_info[i][j].ovc_is_assigned)
                          || (ivc_info[i][j].ivc_req && ivc_info[i][j].ovc_is_assigned
                              && ivc_info[i][j].assigned_ovc_not_full);
            end
            vc_win[i]    = rr_pick(8'(vc_req), V, vc_ptr[i]);
            bid_dest[i]  = (vc_win[i] >= 0) ? ivc_info[i][vc_win[i]].dest_port : '0;
            exp_grant[i] = '0;
            exp_dest[i]  = '0;
        end
        for (int o = 0; o < P; o++) begin
            oreq = '0;
            for (int j = 0; j < P; j++) begin
                if (j != o) begin
                    oreq[(j < o) ? j : j - 1] = bid_dest[j][rel_bit(j, o)];
                end
            end
            out_pos[o]   = rr_pick(8'(oreq), P_1, out_ptr[o]);
            exp_alloc[o] = '0;
            if (out_pos[o] >= 0) begin
                jw = (out_pos[o] < o) ? out_pos[o] : out_pos[o] + 1;
                exp_any[o] = 1'b1;
                exp_dest[jw][rel_bit(jw, o)] = 1'b1;
                if (!ivc_info[jw][vc_win[jw]].ovc_is_assigned && cand_idx[jw][vc_win[jw]] >= 0) begin
                    exp_alloc[o][cand_idx[jw][vc_win[jw]]] = 1'b1;
                end
            end
        end
        for (int i = 0; i < P; i++) begin
            if (exp_dest[i] != '0) begin
                exp_grant[i].sw_grant[vc_win[i]] = 1'b1;
                if (cand_idx[i][vc_win[i]] >= 0) begin
                    exp_grant[i].granted_ovc[cand_idx[i][vc_win[i]]] = 1'b1;
                end
                if (!ivc_info[i][vc_win[i]].ovc_is_assigned) begin
                    exp_grant[i].ovc_grant = exp_grant[i].sw_grant;
                end
            end
            check_value("sw_grant", i, 16'(port_grant[i].sw_grant), 16'(exp_grant[i].sw_grant));
            check_value("ovc_grant", i, 16'(port_grant[i].ovc_grant), 16'(exp_grant[i].ovc_grant));
            check_value("granted_ovc", i, 16'(port_grant[i].granted_ovc),
                        16'(exp_grant[i].granted_ovc));
            check_value("granted_dest_port", i, 16'(granted_dest_port[i]), 16'(exp_dest[i]));
            check_value("ovc_allocated", i, 16'(ovc_allocated[i]), 16'(exp_alloc[i]));
        end
        check_value("any_ovc_granted", 0, 16'(any_ovc_granted), 16'(exp_any));

        // pointer moves that the coming edge will make
        for (int i = 0; i < P; i++) begin
            for (int j = 0; j < V; j++) begin
                if (cand_idx[i][j] >= 0) begin
                    cand_ptr[i][j] = (cand_idx[i][j] + 1) % V;
                end
            end
            if (exp_dest[i] != '0) begin
                vc_ptr[i] = (vc_win[i] + 1) % V;
            end
            if (out_pos[i] >= 0) begin
                out_ptr[i] = (out_pos[i] + 1) % P_1;
            end
        end
    endtask

    task automatic run_cycle();
        @(posedge clk);
        #5;
        ivc_info = stim;
        #40; // settled well before the next edge
        check_cycle();
    endtask

    task automatic clear_stim();
        for (int i = 0; i < P; i++) begin
            for (int j = 0; j < V; j++) begin
                stim[i][j] = '0;
            end
        end
    endtask

    // out_port is absolute, turned into the relative dest bit here
    task automatic set_vc(input int i, input int j, input logic req, input logic asg,
                          input logic nf, input vc_mask_t ovc_req, input int out_port);
        stim[i][j].ivc_req               = req;
        stim[i][j].ovc_is_assigned       = asg;
        stim[i][j].assigned_ovc_not_full = nf;
        stim[i][j].ovc_request           = ovc_req;
        stim[i][j].dest_port             = '0;
        stim[i][j].dest_port[rel_bit(i, out_port)] = 1'b1;
    endtask

    task automatic test_idle();
        clear_stim();
        for (int c = 0; c < 2; c++) begin
            run_cycle();
            for (int i = 0; i < P; i++) begin
                check_value("port_grant", i, 16'(port_grant[i]), 16'h0);
                check_value("granted_dest_port", i, 16'(granted_dest_port[i]), 16'h0);
                check_value("ovc_allocated", i, 16'(ovc_allocated[i]), 16'h0);
            end
            check_value("any_ovc_granted", 0, 16'(any_ovc_granted), 16'h0);
        end
    endtask

    task automatic test_single_unassigned();
        clear_stim();
        set_vc(1, 2, 1'b1, 1'b0, 1'b0, 4'b0110, 3);
        run_cycle();
        check_value("sw_grant", 1, 16'(port_grant[1].sw_grant), 16'h4);
        check_value("ovc_grant", 1, 16'(port_grant[1].ovc_grant), 16'h4);
        check_value("granted_ovc", 1, 16'(port_grant[1].granted_ovc), 16'h2);
        check_value("granted_dest_port", 1, 16'(granted_dest_port[1]), 16'h4);
        check_value("ovc_allocated", 3, 16'(ovc_allocated[3]), 16'h2);
        check_value("any_ovc_granted", 0, 16'(any_ovc_granted), 16'h08);
    endtask

    task automatic test_assigned();
        clear_stim();
        set_vc(2, 0, 1'b1, 1'b1, 1'b1, 4'b0011, 0); // free ovcs seen but not wanted
        run_cycle();
        check_value("sw_grant", 2, 16'(port_grant[2].sw_grant), 16'h1);
        check_value("ovc_grant", 2, 16'(port_grant[2].ovc_grant), 16'h0);
        check_value("ovc_allocated", 0, 16'(ovc_allocated[0]), 16'h0);
        stim[2][0].assigned_ovc_not_full = 1'b0; // output vc full, no request left
        run_cycle();
        check_value("port_grant", 2, 16'(port_grant[2]), 16'h0);
        check_value("granted_dest_port", 2, 16'(granted_dest_port[2]), 16'h0);
        check_value("any_ovc_granted", 0, 16'(any_ovc_granted), 16'h0);
    endtask

    task automatic test_output_contention();
        int winner;
        int loser;

        clear_stim();
        set_vc(0, 0, 1'b1, 1'b1, 1'b1, 4'b0000, 1);
        set_vc(3, 0, 1'b1, 1'b1, 1'b1, 4'b0000, 1);
        for (int c = 0; c < 6; c++) begin
            run_cycle();
            winner = (c % 2 == 0) ? 0 : 3; // lower index first, then alternate
            loser  = (c % 2 == 0) ? 3 : 0;
            check_value("sw_grant", winner, 16'(port_grant[winner].sw_grant), 16'h1);
            check_value("sw_grant", loser, 16'(port_grant[loser].sw_grant), 16'h0);
        end
    endtask

    task automatic test_vc_rotation();
        int last_vc;
        int win_vc;
        int wins;

        last_vc = -1;
        wins    = 0;
        clear_stim();
        set_vc(4, 1, 1'b1, 1'b1, 1'b1, 4'b0000, 0);
        set_vc(4, 3, 1'b1, 1'b1, 1'b1, 4'b0000, 2);
        set_vc(1, 0, 1'b1, 1'b1, 1'b1, 4'b0000, 0); // competes with vc 1 of port 4
        set_vc(2, 0, 1'b1, 1'b1, 1'b1, 4'b0000, 0); // makes port 4 lose now and then
        for (int c = 0; c < 12; c++) begin
            run_cycle();
            if (port_grant[4].sw_grant != '0) begin
                win_vc = 0;
                for (int v = 0; v < V; v++) begin
                    if (port_grant[4].sw_grant[v]) begin
                        win_vc = v;
                    end
                end
                if (win_vc == last_vc) begin
                    error_count++;
                    $display("port 4 won with vc %0d twice in a row at %0t", win_vc, $time);
                end
                last_vc = win_vc;
                wins++;
            end
        end
        if (wins == 0) begin
            error_count++;
            $display("port 4 never won an output during the rotation test");
        end
    endtask

    task automatic test_random();
        int hits;

        for (int c = 0; c < 200; c++) begin
            for (int i = 0; i < P; i++) begin
                for (int j = 0; j < V; j++) begin
                    stim[i][j].ivc_req               = 1'($urandom_range(0, 1));
                    stim[i][j].ovc_is_assigned       = 1'($urandom_range(0, 1));
                    stim[i][j].assigned_ovc_not_full = 1'($urandom_range(0, 1));
                    stim[i][j].ovc_request           = 4'($urandom_range(0, 15));
                    stim[i][j].dest_port             = '0;
                    stim[i][j].dest_port[$urandom_range(0, P_1 - 1)] = 1'b1;
                end
            end
            run_cycle();
            for (int o = 0; o < P; o++) begin
                hits = 0;
                for (int j = 0; j < P; j++) begin
                    if (j != o && granted_dest_port[j][rel_bit(j, o)]) begin
                        hits++;
                    end
                end
                if (hits > 1) begin
                    error_count++;
                    $display("output %0d granted %0d inputs at %0t", o, hits, $time);
                end
            end
        end
    endtask

    initial begin
        void'($urandom(83003));
        error_count = 0;
        check_count = 0;
        reset = 1'b1;
        clear_stim();
        ivc_info = stim;
        for (int i = 0; i < P; i++) begin
            vc_ptr[i]  = 0;
            out_ptr[i] = 0;
            for (int j = 0; j < V; j++) begin
                cand_ptr[i][j] = 0;
            end
        end
        for (int c = 0; c < 2; c++) begin
            @(posedge clk);
        end
        #5;
        reset = 1'b0;

        test_idle();
        test_single_unassigned();
        test_assigned();
        test_output_contention();
        test_vc_rotation();
        test_random();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tests/comb_nonspec_allocator_chk.sv
`timescale 1ns/1ps

module comb_nonspec_allocator_chk
    import noc_params_pkg::*;
    import alloc_types_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input port_grant_t port_grant [P],
    input dest_mask_t  granted_dest_port [P],
    input port_mask_t  any_ovc_granted
);

    port_mask_t dest_hit; // outputs reached by some granted destination

    always_comb begin
        dest_hit = '0;
        for (int j = 0; j < P; j++) begin
            for (int d = 0; d < P_1; d++) begin
                if (granted_dest_port[j][d]) begin
                    if (d < j) begin
                        dest_hit[d] = 1'b1;
                    end else begin
                        dest_hit[d + 1] = 1'b1;
                    end
                end
            end
        end
    end

    for (genvar i = 0; i < P; i++) begin : g_port
        // one switch winner per port, present exactly when the port holds an output
        a_sw_onehot: assert property (@(posedge clk) disable iff (reset)
            $onehot0(port_grant[i].sw_grant)
            && ((|port_grant[i].sw_grant) == (|granted_dest_port[i])))
            else $error("input %0d sw_grant is not one winner matching its output grant", i);

        a_dest_onehot: assert property (@(posedge clk) disable iff (reset)
            $onehot0(granted_dest_port[i]))
            else $error("input %0d granted more than one destination", i);

        // output side agrees with the per input grants
        a_any_match: assert property (@(posedge clk) disable iff (reset)
            any_ovc_granted[i] == dest_hit[i])
            else $error("any_ovc_granted of output %0d disagrees with granted_dest_port", i);
    end

endmodule

// File: source/comb_nonspec_allocator.sv
`timescale 1ns/1ps

module comb_nonspec_allocator
    import noc_params_pkg::*;
    import alloc_types_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  ivc_info_t   ivc_info [P][V],
    output port_grant_t port_grant [P],
    output dest_mask_t  granted_dest_port [P],
    output vc_mask_t    ovc_allocated [P],   // indexed by output port
    output port_mask_t  any_ovc_granted
);

    vc_mask_t   req_masked [P];
    vc_mask_t   cand_ovc [P][V];
    vc_mask_t   assigned [P];
    port_bid_t  bid [P];
    port_mask_t any_sw_grant;

    ovc_candidate_select i_ovc_candidate_select (
        .clk        (clk),
        .reset      (reset),
        .ivc_info   (ivc_info),
        .req_masked (req_masked),
        .cand_ovc   (cand_ovc),
        .assigned   (assigned)
    );

    for (genvar i = 0; i < P; i++) begin : g_in_port
        dest_mask_t vc_dest [V];

        for (genvar j = 0; j < V; j++) begin : g_vc
            assign vc_dest[j] = ivc_info[i][j].dest_port;
        end

        input_port_alloc i_input_port_alloc (
            .clk          (clk),
            .reset        (reset),
            .req_masked   (req_masked[i]),
            .cand_ovc     (cand_ovc[i]),
            .dest         (vc_dest),
            .assigned     (assigned[i]),
            .any_sw_grant (any_sw_grant[i]),
            .bid          (bid[i]),
            .grant        (port_grant[i])
        );
    end

    output_port_alloc i_output_port_alloc (
        .clk               (clk),
        .reset             (reset),
        .bid               (bid),
        .granted_dest_port (granted_dest_port),
        .any_sw_grant      (any_sw_grant),
        .ovc_allocated     (ovc_allocated),
        .any_ovc_granted   (any_ovc_granted)
    );

endmodule

// File: source/output_port_alloc.sv
`timescale 1ns/1ps

module output_port_alloc
    import noc_params_pkg::*;
    import alloc_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  port_bid_t  bid [P],
    output dest_mask_t granted_dest_port [P], // per input, relative bits
    output port_mask_t any_sw_grant,          // per input
    output vc_mask_t   ovc_allocated [P],     // per output
    output port_mask_t any_ovc_granted        // per output
);

    // arbiter o sees inputs in rising order with input o left out,
    // so input j sits at bit j below o and at bit j-1 above it
    logic [P_1-1:0] arb_req [P];
    logic [P_1-1:0] arb_grant [P];
    logic           arb_any [P];

    // regroup bids by output port
    always_comb begin
        for (int o = 0; o < P; o++) begin
            arb_req[o] = '0;
            for (int j = 0; j < P; j++) begin
                if (j < o) begin
                    arb_req[o][j] = bid[j].dest[o-1];
                end else if (j > o) begin
                    arb_req[o][j-1] = bid[j].dest[o];
                end
            end
        end
    end

    for (genvar o = 0; o < P; o++) begin : g_out_port
        rr_arbiter #(
            .width (P_1)
        ) i_port_arbiter (
            .clk         (clk),
            .reset       (reset),
            .request     (arb_req[o]),
            .priority_en (arb_any[o]),
            .grant       (arb_grant[o]),
            .any_grant   (arb_any[o])
        );
    end

    // map each output grant back to the winner's relative destination bit
    always_comb begin
        for (int j = 0; j < P; j++) begin
            granted_dest_port[j] = '0;
        end
        for (int o = 0; o < P; o++) begin
            for (int j = 0; j < P; j++) begin
                if (j < o) begin
                    granted_dest_port[j][o-1] = arb_grant[o][j];
                end else if (j > o) begin
                    granted_dest_port[j][o] = arb_grant[o][j-1];
                end
            end
        end
    end

    always_comb begin
        for (int j = 0; j < P; j++) begin
            any_sw_grant[j] = |granted_dest_port[j];
        end
    end

    // output vc taken at each output, bid already zeroed for assigned winners
    always_comb begin
        for (int o = 0; o < P; o++) begin
            ovc_allocated[o]   = '0;
            any_ovc_granted[o] = arb_any[o];
            for (int j = 0; j < P; j++) begin
                if (j < o && arb_grant[o][j]) begin
                    ovc_allocated[o] = ovc_allocated[o] | bid[j].cand_ovc;
                end else if (j > o && arb_grant[o][j-1]) begin
                    ovc_allocated[o] = ovc_allocated[o] | bid[j].cand_ovc;
                end
            end
        end
    end

endmodule

// File: source/input_port_alloc.sv
`timescale 1ns/1ps

module input_port_alloc
    import noc_params_pkg::*;
    import alloc_types_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  vc_mask_t    req_masked,
    input  vc_mask_t    cand_ovc [V],
    input  dest_mask_t  dest [V],
    input  vc_mask_t    assigned,
    input  logic        any_sw_grant, // this port won an output
    output port_bid_t   bid,
    output port_grant_t grant
);

    vc_mask_t   vc_winner;    // first level grant, one-hot or zero
    logic       vc_any;       // some vc of this port requests
    dest_mask_t win_dest;
    vc_mask_t   win_cand;
    logic       win_assigned; // winner keeps its output vc

    // priority moves only when the port also wins the output stage,
    // so a losing vc keeps its turn
    rr_arbiter #(
        .width (V)
    ) i_vc_arbiter (
        .clk         (clk),
        .reset       (reset),
        .request     (req_masked),
        .priority_en (any_sw_grant),
        .grant       (vc_winner),
        .any_grant   (vc_any)
    );

    // one-hot mux of the winner's fields
    always_comb begin
        win_dest     = '0;
        win_cand     = '0;
        win_assigned = 1'b0;
        for (int v = 0; v < V; v++) begin
            if (vc_winner[v]) begin
                win_dest     = win_dest | dest[v];
                win_cand     = win_cand | cand_ovc[v];
                win_assigned = win_assigned | assigned[v];
            end
        end
    end

    // bid toward the output stage
    always_comb begin
        bid.dest = vc_any ? win_dest : '0;
        if (win_assigned) begin
            bid.cand_ovc = '0; // no new output vc to hand out
        end else begin
            bid.cand_ovc = win_cand;
        end
    end

    // grant record, gated by the output stage result
    always_comb begin
        grant.sw_grant    = '0;
        grant.ovc_grant   = '0;
        grant.granted_ovc = '0;
        if (any_sw_grant) begin
            grant.sw_grant    = vc_winner;
            grant.granted_ovc = win_cand; // taken before the assigned zeroing
            if (!win_assigned) begin
                grant.ovc_grant = vc_winner;
            end
        end
    end

endmodule

// File: source/ovc_candidate_select.sv
`timescale 1ns/1ps

module ovc_candidate_select
    import noc_params_pkg::*;
    import alloc_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  ivc_info_t ivc_info [P][V],
    output vc_mask_t  req_masked [P],
    output vc_mask_t  cand_ovc [P][V],
    output vc_mask_t  assigned [P]
);

    logic cand_any [P][V]; // candidate arbiter sees a request

    // switch request per input vc
    always_comb begin
        logic new_req;  // needs a fresh output vc and one is free
        logic keep_req; // already owns an output vc with room

        for (int i = 0; i < P; i++) begin
            for (int j = 0; j < V; j++) begin
                new_req  = (|ivc_info[i][j].ovc_request) & ~ivc_info[i][j].ovc_is_assigned;
                keep_req = ivc_info[i][j].ivc_req
                         & ivc_info[i][j].ovc_is_assigned
                         & ivc_info[i][j].assigned_ovc_not_full;
                req_masked[i][j] = new_req | keep_req;
                assigned[i][j]   = ivc_info[i][j].ovc_is_assigned;
            end
        end
    end

    // one candidate output vc per input vc, picked before the switch stages
    for (genvar i = 0; i < P; i++) begin : g_port
        for (genvar j = 0; j < V; j++) begin : g_vc
            rr_arbiter #(
                .width (V)
            ) i_ovc_arbiter (
                .clk         (clk),
                .reset       (reset),
                .request     (ivc_info[i][j].ovc_request),
                .priority_en (cand_any[i][j]), // rotates whenever it picks
                .grant       (cand_ovc[i][j]),
                .any_grant   (cand_any[i][j])
            );
        end
    end

endmodule

// File: source/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int width = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [width-1:0] request,
    input  logic             priority_en,
    output logic [width-1:0] grant,
    output logic             any_grant
);

    logic [width-1:0] pointer;    // one-hot, requester with top priority
    logic [width-1:0] above_mask; // bits at or above the pointer
    logic [width-1:0] masked_req;
    logic [width-1:0] pick_from;

    assign above_mask = ~(pointer - width'(1));
    assign masked_req = request & above_mask;

    // nothing at or above the pointer, so wrap to the bottom
    assign pick_from = (|masked_req) ? masked_req : request;

    assign grant     = pick_from & (~pick_from + width'(1)); // lowest set bit
    assign any_grant = |request;

    // priority only moves when the caller says the grant was used
    always_ff @(posedge clk) begin
        if (reset) begin
            pointer <= width'(1);
        end else if (priority_en && any_grant) begin
            pointer <= {grant[width-2:0], grant[width-1]}; // one past the winner
        end
    end

endmodule

// File: source/alloc_types_pkg.sv
package alloc_types_pkg;

    import noc_params_pkg::*;

    // status of one input vc, sampled by the allocator every cycle
    typedef struct packed {
        logic       ivc_req;               // flit waiting in this vc
        logic       ovc_is_assigned;       // packet already owns an output vc
        logic       assigned_ovc_not_full; // room left in that output vc
        vc_mask_t   ovc_request;           // free output vcs it may take
        dest_mask_t dest_port;             // one-hot, relative to the input
    } ivc_info_t;

    // what one input port offers to the output stage
    typedef struct packed {
        dest_mask_t dest;     // zero when the port has no bid
        vc_mask_t   cand_ovc; // zero when the winner already holds an output vc
    } port_bid_t;

    // result handed back to one input port
    typedef struct packed {
        vc_mask_t sw_grant;    // input vc that got the switch
        vc_mask_t ovc_grant;   // input vc that got a new output vc
        vc_mask_t granted_ovc; // candidate output vc of the winner
    } port_grant_t;

endpackage

// File: source/noc_params_pkg.sv
package noc_params_pkg;

    // router geometry
    localparam int P   = 5;     // ports, local included
    localparam int V   = 4;     // vcs per port
    localparam int P_1 = P - 1; // destinations reachable from one input, no self loop

    // one bit per vc
    // as a grant it is one-hot or zero
    typedef logic [V-1:0] vc_mask_t;

    // destination relative to the input port
    // bit d is output d when d is below the input index, else output d+1
    typedef logic [P_1-1:0] dest_mask_t;

    // one bit per router port
    typedef logic [P-1:0] port_mask_t;

endpackage
